// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := int_pipe_tb
FILELIST  := int_pipe.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	-./$(SIM_BIN) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== int_pipe.f ====
source/rv_isa_pkg.sv
source/core_pipe_pkg.sv
source/inst_decode.sv
source/alu_execute.sv
source/reg_file.sv
source/int_pipe_top.sv
verification/int_pipe_properties.sv
verification/int_pipe_tb.sv

// ==== source/alu_execute.sv ====
`default_nettype none

module alu_execute (
    input  logic                         clk,
    input  logic                         rst_n,
    input  core_pipe_pkg::decoded_inst_t decoded,
    output rv_isa_pkg::reg_addr_t        rs1_num,
    output rv_isa_pkg::reg_addr_t        rs2_num,
    input  rv_isa_pkg::word_t            rs1_data,
    input  rv_isa_pkg::word_t            rs2_data,
    output core_pipe_pkg::result_t       result
);

    rv_isa_pkg::word_t  op_a;
    rv_isa_pkg::word_t  rs2_fwd;
    rv_isa_pkg::word_t  op_b;
    rv_isa_pkg::shamt_t shamt;
    rv_isa_pkg::word_t  alu_out;

    // register file read addresses
    assign rs1_num = decoded.rs1;
    assign rs2_num = decoded.rs2;

    // forward own previous result; rd == x0 already excluded by wen
    always_comb begin
        if (result.wen && (result.rd == decoded.rs1)) begin
            op_a = result.data;
        end else begin
            op_a = rs1_data;
        end

        if (result.wen && (result.rd == decoded.rs2)) begin
            rs2_fwd = result.data;
        end else begin
            rs2_fwd = rs2_data;
        end
    end

    assign op_b  = decoded.use_imm ? decoded.imm : rs2_fwd;
    assign shamt = op_b[4:0];

    always_comb begin
        case (decoded.alu_op)
            core_pipe_pkg::ALU_ADD:    alu_out = op_a + op_b;
            core_pipe_pkg::ALU_SUB:    alu_out = op_a - op_b;
            core_pipe_pkg::ALU_SLL:    alu_out = op_a << shamt;
            core_pipe_pkg::ALU_SLT: begin
                alu_out = rv_isa_pkg::word_t'($signed(op_a) < $signed(op_b));
            end
            core_pipe_pkg::ALU_SLTU: begin
                alu_out = rv_isa_pkg::word_t'(op_a < op_b);
            end
            core_pipe_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            core_pipe_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            // arithmetic shift keeps the sign
            core_pipe_pkg::ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            core_pipe_pkg::ALU_OR:     alu_out = op_a | op_b;
            core_pipe_pkg::ALU_AND:    alu_out = op_a & op_b;
            core_pipe_pkg::ALU_PASS_B: alu_out = op_b;
            default:                   alu_out = '0;
        endcase
    end

    // result register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result.valid <= 1'b0;
            result.wen   <= 1'b0;
        end else begin
            result.valid <= decoded.valid;
            result.wen   <= decoded.wen;
            result.rd    <= decoded.rd;
            result.data  <= alu_out;
        end
    end

endmodule

`default_nettype wire

// ==== source/core_pipe_pkg.sv ====
`default_nettype none

package core_pipe_pkg;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // operand b straight through, for LUI
        ALU_PASS_B
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        // only for legal instructions with rd != x0
        logic                  wen;
        alu_op_e               alu_op;
        logic                  use_imm;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     imm;
    } decoded_inst_t;

    // execute to register file and outputs
    typedef struct packed {
        logic                  valid;
        logic                  wen;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     data;
    } result_t;

endpackage

`default_nettype wire

// ==== source/inst_decode.sv ====
`default_nettype none

module inst_decode (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         inst_valid,
    input  rv_isa_pkg::inst_word_t       inst_code,
    output core_pipe_pkg::decoded_inst_t decoded,
    output logic                         illegal
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    rv_isa_pkg::reg_addr_t   rd;
    rv_isa_pkg::reg_addr_t   rs1;
    rv_isa_pkg::reg_addr_t   rs2;
    rv_isa_pkg::word_t       imm_i;
    rv_isa_pkg::word_t       imm_u;
    logic                    legal;
    logic                    use_imm;
    core_pipe_pkg::alu_op_e  alu_op;
    rv_isa_pkg::word_t       imm;

    // instruction fields
    assign opcode = inst_code[6:0];
    assign rd     = inst_code[11:7];
    assign funct3 = inst_code[14:12];
    assign rs1    = inst_code[19:15];
    assign rs2    = inst_code[24:20];
    assign funct7 = inst_code[31:25];

    assign imm_i = {{20{inst_code[31]}}, inst_code[31:20]};
    assign imm_u = {inst_code[31:12], 12'h000};

    // operation for funct7 = base
    function automatic core_pipe_pkg::alu_op_e base_op(input logic [2:0] f3);
        core_pipe_pkg::alu_op_e op;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: op = core_pipe_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     op = core_pipe_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     op = core_pipe_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    op = core_pipe_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     op = core_pipe_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: op = core_pipe_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      op = core_pipe_pkg::ALU_OR;
            default:                op = core_pipe_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        legal   = 1'b0;
        alu_op  = base_op(funct3);
        use_imm = 1'b0;
        imm     = imm_i;
        case (opcode)
            rv_isa_pkg::OPCODE_OP: begin
                if (funct7 == rv_isa_pkg::FUNCT7_BASE) begin
                    legal = 1'b1;
                end else if (funct7 == rv_isa_pkg::FUNCT7_ALT) begin
                    // only SUB and SRA have an alternate form
                    legal = (funct3 == rv_isa_pkg::F3_ADD_SUB) ||
                            (funct3 == rv_isa_pkg::F3_SRL_SRA);
                    alu_op = (funct3 == rv_isa_pkg::F3_ADD_SUB) ? core_pipe_pkg::ALU_SUB
                                                                : core_pipe_pkg::ALU_SRA;
                end
            end
            rv_isa_pkg::OPCODE_OP_IMM: begin
                use_imm = 1'b1;
                if (funct3 == rv_isa_pkg::F3_SLL) begin
                    legal = (funct7 == rv_isa_pkg::FUNCT7_BASE);
                end else if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
                    legal = (funct7 == rv_isa_pkg::FUNCT7_BASE) ||
                            (funct7 == rv_isa_pkg::FUNCT7_ALT);
                    if (funct7 == rv_isa_pkg::FUNCT7_ALT) begin
                        alu_op = core_pipe_pkg::ALU_SRA;
                    end
                end else begin
                    legal = 1'b1;
                end
            end
            rv_isa_pkg::OPCODE_LUI: begin
                legal   = 1'b1;
                alu_op  = core_pipe_pkg::ALU_PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // decode register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decoded.valid <= 1'b0;
            decoded.wen   <= 1'b0;
            illegal       <= 1'b0;
        end else begin
            decoded.valid   <= inst_valid && legal;
            decoded.wen     <= inst_valid && legal && (rd != '0);
            decoded.alu_op  <= alu_op;
            decoded.use_imm <= use_imm;
            decoded.rs1     <= rs1;
            decoded.rs2     <= rs2;
            decoded.rd      <= rd;
            decoded.imm     <= imm;
            illegal         <= inst_valid && !legal;
        end
    end

endmodule

`default_nettype wire

// ==== source/int_pipe_top.sv ====
`default_nettype none

module int_pipe_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  rv_isa_pkg::inst_word_t inst_code,
    output logic                   wb_valid,
    output rv_isa_pkg::reg_addr_t  wb_rd,
    output rv_isa_pkg::word_t      wb_data,
    output logic                   illegal
);

    core_pipe_pkg::decoded_inst_t decoded;
    core_pipe_pkg::result_t       result;
    rv_isa_pkg::reg_addr_t        rs1_num;
    rv_isa_pkg::reg_addr_t        rs2_num;
    rv_isa_pkg::word_t            rs1_data;
    rv_isa_pkg::word_t            rs2_data;

    inst_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_valid(inst_valid),
        .inst_code (inst_code),
        .decoded   (decoded),
        .illegal   (illegal)
    );

    alu_execute u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .decoded (decoded),
        .rs1_num (rs1_num),
        .rs2_num (rs2_num),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .result  (result)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_num (rs1_num),
        .rs2_num (rs2_num),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .result  (result)
    );

    // write-back report, same cycle as the register write
    assign wb_valid = result.wen;
    assign wb_rd    = result.rd;
    assign wb_data  = result.data;

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`default_nettype none

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_isa_pkg::reg_addr_t  rs1_num,
    input  rv_isa_pkg::reg_addr_t  rs2_num,
    output rv_isa_pkg::word_t      rs1_data,
    output rv_isa_pkg::word_t      rs2_data,
    input  core_pipe_pkg::result_t result
);

    rv_isa_pkg::word_t regs [rv_isa_pkg::NUM_REGS];

    // combinational reads
    assign rs1_data = regs[rs1_num];
    assign rs2_data = regs[rs2_num];

    // x0 stays zero since wen is never set for rd 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (result.wen) begin
            regs[result.rd] <= result.data;
        end
    end

endmodule

`default_nettype wire

// ==== source/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // data and instruction words
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_word_t;

    // register number and shift amount
    typedef logic [4:0] reg_addr_t;
    typedef logic [4:0] shamt_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    // funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 codes
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    // selects SUB and SRA
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // integer register count
    localparam int NUM_REGS = 32;

endpackage

`default_nettype wire

// ==== verification/int_pipe_properties.sv ====
`default_nettype none

module int_pipe_properties (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         wb_valid,
    input rv_isa_pkg::reg_addr_t        wb_rd,
    input logic                         illegal,
    input core_pipe_pkg::decoded_inst_t decoded
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // x0 never shows up as a write-back target
    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb_rd != '0))
        else begin
            $error("write-back reported for x0");
            fail_count++;
        end

    // illegal instruction never decodes as valid and never reaches write-back
    a_illegal_not_valid: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> !decoded.valid ##1 !wb_valid)
        else begin
            $error("illegal instruction decoded as valid or written back");
            fail_count++;
        end

    // pipeline comes out of reset empty
    a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid)
        else begin
            $error("wb_valid high right after reset release");
            fail_count++;
        end

endmodule

bind int_pipe_top int_pipe_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_valid(wb_valid),
    .wb_rd   (wb_rd),
    .illegal (illegal),
    .decoded (decoded)
);

`default_nettype wire

// ==== verification/int_pipe_tb.sv ====
`default_nettype none

module int_pipe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        rv_isa_pkg::inst_word_t code;
        logic                   valid;
        logic                   illegal;
        logic                   wen;
        rv_isa_pkg::reg_addr_t  rd;
        rv_isa_pkg::word_t      data;
    } vec_t;

    logic                   clk;
    logic                   rst_n;
    logic                   inst_valid;
    rv_isa_pkg::inst_word_t inst_code;
    logic                   wb_valid;
    rv_isa_pkg::reg_addr_t  wb_rd;
    rv_isa_pkg::word_t      wb_data;
    logic                   illegal;

    vec_t vectors[$];
    vec_t ill_q[$];
    vec_t wb_q[$];
    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   cycle_limit = 0;

    int_pipe_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_valid(inst_valid),
        .inst_code (inst_code),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // hand encoders for the three formats used
    function automatic rv_isa_pkg::inst_word_t r_type(input logic [6:0] f7,
            input rv_isa_pkg::reg_addr_t rs2, input rv_isa_pkg::reg_addr_t rs1,
            input logic [2:0] f3, input rv_isa_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_isa_pkg::inst_word_t i_type(input logic [11:0] imm,
            input rv_isa_pkg::reg_addr_t rs1, input logic [2:0] f3,
            input rv_isa_pkg::reg_addr_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic rv_isa_pkg::inst_word_t u_type(input logic [19:0] imm,
            input rv_isa_pkg::reg_addr_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic add_entry(input rv_isa_pkg::inst_word_t code, input logic valid,
            input logic ill, input logic wen, input rv_isa_pkg::reg_addr_t rd,
            input rv_isa_pkg::word_t data);
        vectors.push_back('{code, valid, ill, wen, rd, data});
    endtask

    task automatic check_word(input string name, input rv_isa_pkg::word_t expected,
            input rv_isa_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input rv_isa_pkg::reg_addr_t expected,
            input rv_isa_pkg::reg_addr_t actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %0d ns: %s expected %b, got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_illegal_out();
        vec_t want;
        if (ill_q.size() == 0) begin
            $display("no expected illegal flag left to compare at %0d ns", $time);
            errors++;
        end else begin
            want = ill_q.pop_front();
            check_bit("illegal", want.illegal, illegal);
        end
    endtask

    task automatic check_writeback();
        vec_t want;
        if (wb_q.size() == 0) begin
            $display("no expected write-back left to compare at %0d ns", $time);
            errors++;
        end else begin
            want = wb_q.pop_front();
            check_bit("wb_valid", want.wen, wb_valid);
            if (want.wen) begin
                check_reg("wb_rd", want.rd, wb_rd);
                check_word("wb_data", want.data, wb_data);
            end
        end
    endtask

    // expected values follow the RV32I rules with all registers starting at 0
    task automatic build_vectors();
        add_entry(i_type(12'h005, 5'd0, 3'b000, 5'd1), 1'b1, 1'b0, 1'b1, 5'd1, 32'h5);
        add_entry(i_type(12'hFFD, 5'd0, 3'b000, 5'd2), 1'b1, 1'b0, 1'b1, 5'd2, 32'hFFFFFFFD);
        // slti/sltiu on x2 at distance 1 and 2
        add_entry(i_type(12'hFFE, 5'd2, 3'b010, 5'd3), 1'b1, 1'b0, 1'b1, 5'd3, 32'h1);
        add_entry(i_type(12'h007, 5'd2, 3'b011, 5'd4), 1'b1, 1'b0, 1'b1, 5'd4, 32'h0);
        add_entry(i_type(12'h0F0, 5'd1, 3'b100, 5'd5), 1'b1, 1'b0, 1'b1, 5'd5, 32'hF5);
        add_entry(i_type(12'h800, 5'd1, 3'b110, 5'd6), 1'b1, 1'b0, 1'b1, 5'd6, 32'hFFFFF805);
        add_entry(i_type(12'h0FF, 5'd6, 3'b111, 5'd7), 1'b1, 1'b0, 1'b1, 5'd7, 32'h5);
        add_entry(u_type(20'h80000, 5'd8), 1'b1, 1'b0, 1'b1, 5'd8, 32'h80000000);
        add_entry(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), 1'b1, 1'b0, 1'b1, 5'd9, 32'h2);
        add_entry(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd10), 1'b1, 1'b0, 1'b1, 5'd10, 32'h8);
        add_entry(r_type(7'h00, 5'd2, 5'd6, 3'b111, 5'd11), 1'b1, 1'b0, 1'b1, 5'd11, 32'hFFFFF805);
        add_entry(r_type(7'h00, 5'd8, 5'd1, 3'b110, 5'd12), 1'b1, 1'b0, 1'b1, 5'd12, 32'h80000005);
        add_entry(r_type(7'h00, 5'd2, 5'd6, 3'b100, 5'd13), 1'b1, 1'b0, 1'b1, 5'd13, 32'h7F8);
        add_entry(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd14), 1'b1, 1'b0, 1'b1, 5'd14, 32'h1);
        add_entry(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd15), 1'b1, 1'b0, 1'b1, 5'd15, 32'h0);
        // register shifts with the amount from rs2
        add_entry(r_type(7'h00, 5'd10, 5'd1, 3'b001, 5'd16), 1'b1, 1'b0, 1'b1, 5'd16, 32'h500);
        add_entry(r_type(7'h00, 5'd7, 5'd8, 3'b101, 5'd17), 1'b1, 1'b0, 1'b1, 5'd17, 32'h04000000);
        add_entry(r_type(7'h20, 5'd7, 5'd8, 3'b101, 5'd18), 1'b1, 1'b0, 1'b1, 5'd18, 32'hFC000000);
        add_entry(i_type(12'h01F, 5'd1, 3'b001, 5'd19), 1'b1, 1'b0, 1'b1, 5'd19, 32'h80000000);
        add_entry(i_type(12'h01F, 5'd2, 3'b101, 5'd20), 1'b1, 1'b0, 1'b1, 5'd20, 32'h1);
        add_entry(i_type(12'h41F, 5'd8, 3'b101, 5'd21), 1'b1, 1'b0, 1'b1, 5'd21, 32'hFFFFFFFF);
        // dependent chain then a read across a bubble
        add_entry(i_type(12'h064, 5'd0, 3'b000, 5'd22), 1'b1, 1'b0, 1'b1, 5'd22, 32'h64);
        add_entry(i_type(12'h001, 5'd22, 3'b000, 5'd22), 1'b1, 1'b0, 1'b1, 5'd22, 32'h65);
        add_entry(r_type(7'h00, 5'd22, 5'd22, 3'b000, 5'd23), 1'b1, 1'b0, 1'b1, 5'd23, 32'hCA);
        add_entry(r_type(7'h20, 5'd23, 5'd22, 3'b000, 5'd24), 1'b1, 1'b0, 1'b1, 5'd24, 32'hFFFFFF9B);
        add_entry(32'h0, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
        add_entry(i_type(12'h010, 5'd24, 3'b000, 5'd25), 1'b1, 1'b0, 1'b1, 5'd25, 32'hFFFFFFAB);
        // x0 target then x0 read
        add_entry(i_type(12'h005, 5'd1, 3'b000, 5'd0), 1'b1, 1'b0, 1'b0, 5'd0, 32'h0);
        add_entry(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd26), 1'b1, 1'b0, 1'b1, 5'd26, 32'h5);
        // load opcode then slli with alt funct7 and srli with funct7 1
        add_entry({12'h000, 5'd1, 3'b010, 5'd30, 7'b0000011}, 1'b1, 1'b1, 1'b0, 5'd0, 32'h0);
        add_entry(i_type(12'h401, 5'd1, 3'b001, 5'd30), 1'b1, 1'b1, 1'b0, 5'd0, 32'h0);
        add_entry(i_type(12'h021, 5'd1, 3'b101, 5'd30), 1'b1, 1'b1, 1'b0, 5'd0, 32'h0);
        add_entry(r_type(7'h00, 5'd0, 5'd30, 3'b000, 5'd27), 1'b1, 1'b0, 1'b1, 5'd27, 32'h0);
    endtask

    initial begin
        vec_t cur;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst_code  = '0;
        build_vectors();
        cycle_limit = vectors.size() + 5 + 2 + 20;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // two extra bubbles drain the pipeline
        for (int i = 0; i < vectors.size() + 2; i++) begin
            @(posedge clk);
            cur = (i < vectors.size()) ? vectors[i] : '0;
            inst_valid <= cur.valid;
            inst_code  <= cur.code;
            ill_q.push_back(cur);
            wb_q.push_back(cur);
            @(negedge clk);
            if (i >= 1) check_illegal_out();
            if (i >= 2) check_writeback();
        end
        errors += dut.u_props.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_props.fail_count);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run still going after %0d cycles", cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
